/* Bender.yml */
package:
  name: llc

sources:
  - llc_pkg.sv
  - llc_input_reg.sv
  - llc_way_lookup.sv
  - llc_store.sv
  - llc_ctrl.sv
  - llc_top.sv
  - target: test
    files:
      - tb_llc_checker.sv
      - tb_llc.sv

/* llc_ctrl.sv */
module llc_ctrl #(
    parameter int NUM_WAYS = llc_pkg::NUM_WAYS,
    parameter int NUM_SETS = llc_pkg::NUM_SETS,
    localparam int ADDR_BITS = $bits(llc_pkg::line_addr_t),
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_full_i,
    input  llc_pkg::llc_req_t             req_i,
    output logic                          req_take_o,

    input  logic                          mrsp_full_i,
    input  llc_pkg::line_t                mrsp_line_i,
    output logic                          mrsp_take_o,

    output llc_pkg::line_addr_t           lookup_addr_o,
    input  logic                          hit_i,
    input  logic [WAY_BITS-1:0]           way_i,
    input  logic                          victim_dirty_i,
    input  llc_pkg::line_addr_t           victim_addr_i,
    input  llc_pkg::line_t                victim_line_i,
    input  llc_pkg::line_t [NUM_WAYS-1:0] rd_lines_i,

    output logic                          rd_en_o,
    output logic [SET_BITS-1:0]           rd_set_o,
    output logic                          wr_en_o,
    output logic [SET_BITS-1:0]           wr_set_o,
    output logic [WAY_BITS-1:0]           wr_way_o,
    output logic [TAG_BITS-1:0]           wr_tag_o,
    output llc_pkg::line_t                wr_line_o,
    output logic                          wr_dirty_o,
    output logic                          wr_fill_o,

    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output llc_pkg::llc_mem_req_t         mem_req_o,

    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    output llc_pkg::llc_rsp_t             rsp_o
);

    llc_pkg::llc_state_e state_q, state_d;

    llc_pkg::llc_req_t   req_q;
    llc_pkg::line_t      line_q;
    llc_pkg::line_t      merged_line;
    llc_pkg::line_addr_t victim_addr_q;
    logic [WAY_BITS-1:0] way_q;
    logic                hit_q;

    // miss progress flags
    logic wb_q, fill_q, fill_sent_q;
    logic process_done;
    logic is_write;

    assign is_write     = (req_q.op == llc_pkg::LLC_WRITE);
    assign process_done = !wb_q && !fill_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            llc_pkg::LLC_DECODE:   if (req_full_i) state_d = llc_pkg::LLC_READ_SET;
            llc_pkg::LLC_READ_SET: state_d = llc_pkg::LLC_LOOKUP;
            llc_pkg::LLC_LOOKUP:   state_d = llc_pkg::LLC_PROCESS;
            llc_pkg::LLC_PROCESS:  if (process_done) state_d = llc_pkg::LLC_UPDATE;
            llc_pkg::LLC_UPDATE:   state_d = llc_pkg::LLC_RESPOND;
            llc_pkg::LLC_RESPOND:  if (rsp_ready_i) state_d = llc_pkg::LLC_DECODE;
            default:               state_d = llc_pkg::LLC_DECODE;
        endcase
    end

    assign req_take_o  = (state_q == llc_pkg::LLC_DECODE) && req_full_i;
    assign mrsp_take_o = (state_q == llc_pkg::LLC_PROCESS) && fill_sent_q && mrsp_full_i;

    // write-back goes out before the fill read
    assign mem_req_valid_o = (state_q == llc_pkg::LLC_PROCESS) &&
                             (wb_q || (fill_q && !fill_sent_q));
    assign mem_req_o.write = wb_q;
    assign mem_req_o.addr  = wb_q ? victim_addr_q : req_q.addr;
    assign mem_req_o.line  = line_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= llc_pkg::LLC_DECODE;
            wb_q        <= 1'b0;
            fill_q      <= 1'b0;
            fill_sent_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == llc_pkg::LLC_LOOKUP) begin
                wb_q        <= !hit_i && victim_dirty_i;
                fill_q      <= !hit_i;
                fill_sent_q <= 1'b0;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (wb_q) begin
                    wb_q <= 1'b0;
                end else begin
                    fill_sent_q <= 1'b1;
                end
            end
            if (mrsp_take_o) begin
                fill_q <= 1'b0;
            end
        end
    end

    always_comb begin
        merged_line = line_q;
        if (is_write) begin
            merged_line[req_q.offset] = req_q.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take_o) begin
            req_q <= req_i;
        end
        if (state_q == llc_pkg::LLC_LOOKUP) begin
            hit_q         <= hit_i;
            way_q         <= way_i;
            victim_addr_q <= victim_addr_i;
            line_q        <= hit_i ? rd_lines_i[way_i] : victim_line_i;
        end else if (mrsp_take_o) begin
            line_q <= mrsp_line_i;
        end else if (state_q == llc_pkg::LLC_UPDATE) begin
            line_q <= merged_line;
        end
    end

    assign lookup_addr_o = req_q.addr;
    assign rd_en_o       = (state_q == llc_pkg::LLC_READ_SET);
    assign rd_set_o      = req_q.addr[SET_BITS-1:0];

    // read hits leave the store alone
    assign wr_en_o    = (state_q == llc_pkg::LLC_UPDATE) && !(hit_q && !is_write);
    assign wr_set_o   = req_q.addr[SET_BITS-1:0];
    assign wr_way_o   = way_q;
    assign wr_tag_o   = req_q.addr[ADDR_BITS-1:SET_BITS];
    assign wr_line_o  = merged_line;
    assign wr_dirty_o = is_write;
    assign wr_fill_o  = !hit_q;

    assign rsp_valid_o   = (state_q == llc_pkg::LLC_RESPOND);
    assign rsp_o.req_id  = req_q.req_id;
    assign rsp_o.line    = line_q;

endmodule

/* llc_input_reg.sv */
module llc_input_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    input  logic     take_i,

    output logic     full_o,
    output payload_t data_o
);

    logic     full_q;
    payload_t data_q;

    // accept only while empty
    assign ready_o = !full_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            full_q <= 1'b1;
        end else if (take_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign full_o = full_q;
    assign data_o = data_q;

endmodule

/* llc_pkg.sv */
package llc_pkg;

    // defaults for the top-level geometry parameters
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 16;

    // fixed line shape
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS = 32;
    localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);

    localparam int LINE_ADDR_BITS = 12;
    localparam int REQ_ID_BITS = 4;

    // set index in the low bits, tag above it
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    typedef logic [WORD_BITS-1:0] word_t;

    typedef logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] line_t;

    typedef logic [REQ_ID_BITS-1:0] req_id_t;

    typedef logic [OFFSET_BITS-1:0] word_offset_t;

    typedef enum logic {
        LLC_READ  = 1'b0,
        LLC_WRITE = 1'b1
    } llc_op_e;

    typedef struct packed {
        llc_op_e      op;
        req_id_t      req_id;
        line_addr_t   addr;
        word_offset_t offset;
        word_t        wdata;
    } llc_req_t;

    typedef struct packed {
        req_id_t req_id;
        line_t   line;
    } llc_rsp_t;

    // line only meaningful for write-backs
    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      line;
    } llc_mem_req_t;

    typedef enum logic [2:0] {
        LLC_DECODE   = 3'b000,
        LLC_READ_SET = 3'b001,
        LLC_LOOKUP   = 3'b010,
        LLC_PROCESS  = 3'b110,
        LLC_UPDATE   = 3'b100,
        LLC_RESPOND  = 3'b101
    } llc_state_e;

endpackage

/* llc_store.sv */
module llc_store #(
    parameter int NUM_WAYS = llc_pkg::NUM_WAYS,
    parameter int NUM_SETS = llc_pkg::NUM_SETS,
    localparam int ADDR_BITS = $bits(llc_pkg::line_addr_t),
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                rd_en_i,
    input  logic [SET_BITS-1:0]                 rd_set_i,
    output logic [NUM_WAYS-1:0][TAG_BITS-1:0]   rd_tags_o,
    output logic [NUM_WAYS-1:0]                 rd_valid_o,
    output logic [NUM_WAYS-1:0]                 rd_dirty_o,
    output llc_pkg::line_t [NUM_WAYS-1:0]       rd_lines_o,
    output logic [WAY_BITS-1:0]                 rd_evict_way_o,

    input  logic                                wr_en_i,
    input  logic [SET_BITS-1:0]                 wr_set_i,
    input  logic [WAY_BITS-1:0]                 wr_way_i,
    input  logic [TAG_BITS-1:0]                 wr_tag_i,
    input  llc_pkg::line_t                      wr_line_i,
    input  logic                                wr_dirty_i,
    input  logic                                wr_fill_i
);

    logic [NUM_WAYS-1:0][TAG_BITS-1:0] tag_mem [NUM_SETS];
    llc_pkg::line_t [NUM_WAYS-1:0]     line_mem [NUM_SETS];
    logic [NUM_WAYS-1:0]               dirty_mem [NUM_SETS];

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][WAY_BITS-1:0] evict_q;

    // valid bits and round-robin pointers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            evict_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_set_i][wr_way_i] <= 1'b1;
            if (wr_fill_i) begin
                if (evict_q[wr_set_i] == WAY_BITS'(NUM_WAYS - 1)) begin
                    evict_q[wr_set_i] <= '0;
                end else begin
                    evict_q[wr_set_i] <= evict_q[wr_set_i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_set_i][wr_way_i]   <= wr_tag_i;
            line_mem[wr_set_i][wr_way_i]  <= wr_line_i;
            dirty_mem[wr_set_i][wr_way_i] <= wr_dirty_i;
        end
    end

    // whole set comes out one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_tags_o      <= tag_mem[rd_set_i];
            rd_lines_o     <= line_mem[rd_set_i];
            rd_dirty_o     <= dirty_mem[rd_set_i];
            rd_valid_o     <= valid_q[rd_set_i];
            rd_evict_way_o <= evict_q[rd_set_i];
        end
    end

endmodule

/* llc_tests.txt */
// op_id_addr_offset_wdata_stall_reads_writes_word3_word2_word1_word0, all hex
// op 1 is a word write, stall is the cycles rsp ready stays low
0_0_010_0_00000000_0_1_0_00000043_00000042_00000041_00000040
0_1_010_0_00000000_2_0_0_00000043_00000042_00000041_00000040
1_2_010_2_deadbeef_0_0_0_00000043_deadbeef_00000041_00000040
0_3_010_0_00000000_3_0_0_00000043_deadbeef_00000041_00000040
0_4_020_0_00000000_0_1_0_00000083_00000082_00000081_00000080
1_5_030_0_12345678_1_1_0_000000c3_000000c2_000000c1_12345678
0_6_040_0_00000000_0_1_0_00000103_00000102_00000101_00000100
0_7_050_0_00000000_5_1_1_00000143_00000142_00000141_00000140
0_8_010_0_00000000_0_1_0_00000043_deadbeef_00000041_00000040
0_9_020_0_00000000_2_1_1_00000083_00000082_00000081_00000080
0_a_030_0_00000000_0_1_0_000000c3_000000c2_000000c1_12345678
1_b_123_3_cafef00d_4_1_0_cafef00d_0000048e_0000048d_0000048c
0_c_123_0_00000000_0_0_0_cafef00d_0000048e_0000048d_0000048c
1_d_123_1_0badcafe_1_0_0_cafef00d_0000048e_0badcafe_0000048c
0_e_050_0_00000000_0_0_0_00000143_00000142_00000141_00000140
0_f_fff_0_00000000_3_1_0_00003fff_00003ffe_00003ffd_00003ffc
0_0_7f3_2_00000000_0_1_0_00001fcf_00001fce_00001fcd_00001fcc

/* llc_top.sv */
module llc_top #(
    parameter int NUM_WAYS = llc_pkg::NUM_WAYS,
    parameter int NUM_SETS = llc_pkg::NUM_SETS,
    localparam int ADDR_BITS = $bits(llc_pkg::line_addr_t),
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  llc_pkg::llc_req_t     req_i,

    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output llc_pkg::llc_rsp_t     rsp_o,

    output logic                  mem_req_valid_o,
    input  logic                  mem_req_ready_i,
    output llc_pkg::llc_mem_req_t mem_req_o,

    input  logic                  mem_rsp_valid_i,
    output logic                  mem_rsp_ready_o,
    input  llc_pkg::line_t        mem_rsp_i
);

    logic              req_full, req_take;
    llc_pkg::llc_req_t req_q;

    logic           mrsp_full, mrsp_take;
    llc_pkg::line_t mrsp_line;

    llc_pkg::line_addr_t lookup_addr;
    logic                hit;
    logic [WAY_BITS-1:0] way;
    logic                victim_dirty;
    llc_pkg::line_addr_t victim_addr;
    llc_pkg::line_t      victim_line;

    logic                              rd_en;
    logic [SET_BITS-1:0]               rd_set;
    logic [NUM_WAYS-1:0][TAG_BITS-1:0] rd_tags;
    logic [NUM_WAYS-1:0]               rd_valid;
    logic [NUM_WAYS-1:0]               rd_dirty;
    llc_pkg::line_t [NUM_WAYS-1:0]     rd_lines;
    logic [WAY_BITS-1:0]               rd_evict_way;

    logic                wr_en;
    logic [SET_BITS-1:0] wr_set;
    logic [WAY_BITS-1:0] wr_way;
    logic [TAG_BITS-1:0] wr_tag;
    llc_pkg::line_t      wr_line;
    logic                wr_dirty;
    logic                wr_fill;

    llc_input_reg #(
        .payload_t(llc_pkg::llc_req_t)
    ) u_req_reg (
        .clk     (clk),
        .rst     (rst),
        .valid_i (req_valid_i),
        .ready_o (req_ready_o),
        .data_i  (req_i),
        .take_i  (req_take),
        .full_o  (req_full),
        .data_o  (req_q)
    );

    llc_input_reg #(
        .payload_t(llc_pkg::line_t)
    ) u_mrsp_reg (
        .clk     (clk),
        .rst     (rst),
        .valid_i (mem_rsp_valid_i),
        .ready_o (mem_rsp_ready_o),
        .data_i  (mem_rsp_i),
        .take_i  (mrsp_take),
        .full_o  (mrsp_full),
        .data_o  (mrsp_line)
    );

    llc_ctrl #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_SETS(NUM_SETS)
    ) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_full_i      (req_full),
        .req_i           (req_q),
        .req_take_o      (req_take),
        .mrsp_full_i     (mrsp_full),
        .mrsp_line_i     (mrsp_line),
        .mrsp_take_o     (mrsp_take),
        .lookup_addr_o   (lookup_addr),
        .hit_i           (hit),
        .way_i           (way),
        .victim_dirty_i  (victim_dirty),
        .victim_addr_i   (victim_addr),
        .victim_line_i   (victim_line),
        .rd_lines_i      (rd_lines),
        .rd_en_o         (rd_en),
        .rd_set_o        (rd_set),
        .wr_en_o         (wr_en),
        .wr_set_o        (wr_set),
        .wr_way_o        (wr_way),
        .wr_tag_o        (wr_tag),
        .wr_line_o       (wr_line),
        .wr_dirty_o      (wr_dirty),
        .wr_fill_o       (wr_fill),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_o           (rsp_o)
    );

    llc_way_lookup #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_SETS(NUM_SETS)
    ) u_lookup (
        .addr_i         (lookup_addr),
        .rd_tags_i      (rd_tags),
        .rd_valid_i     (rd_valid),
        .rd_dirty_i     (rd_dirty),
        .rd_lines_i     (rd_lines),
        .rd_evict_way_i (rd_evict_way),
        .hit_o          (hit),
        .way_o          (way),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr),
        .victim_line_o  (victim_line)
    );

    llc_store #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_SETS(NUM_SETS)
    ) u_store (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .rd_set_i       (rd_set),
        .rd_tags_o      (rd_tags),
        .rd_valid_o     (rd_valid),
        .rd_dirty_o     (rd_dirty),
        .rd_lines_o     (rd_lines),
        .rd_evict_way_o (rd_evict_way),
        .wr_en_i        (wr_en),
        .wr_set_i       (wr_set),
        .wr_way_i       (wr_way),
        .wr_tag_i       (wr_tag),
        .wr_line_i      (wr_line),
        .wr_dirty_i     (wr_dirty),
        .wr_fill_i      (wr_fill)
    );

endmodule

/* llc_way_lookup.sv */
module llc_way_lookup #(
    parameter int NUM_WAYS = llc_pkg::NUM_WAYS,
    parameter int NUM_SETS = llc_pkg::NUM_SETS,
    localparam int ADDR_BITS = $bits(llc_pkg::line_addr_t),
    localparam int SET_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  llc_pkg::line_addr_t                      addr_i,
    input  logic [NUM_WAYS-1:0][TAG_BITS-1:0]        rd_tags_i,
    input  logic [NUM_WAYS-1:0]                      rd_valid_i,
    input  logic [NUM_WAYS-1:0]                      rd_dirty_i,
    input  llc_pkg::line_t [NUM_WAYS-1:0]            rd_lines_i,
    input  logic [WAY_BITS-1:0]                      rd_evict_way_i,

    output logic                                     hit_o,
    output logic [WAY_BITS-1:0]                      way_o,
    output logic                                     victim_dirty_o,
    output llc_pkg::line_addr_t                      victim_addr_o,
    output llc_pkg::line_t                           victim_line_o
);

    logic [SET_BITS-1:0] set;
    logic [TAG_BITS-1:0] tag;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] free_way;
    logic                have_free;
    logic [WAY_BITS-1:0] victim_way;

    assign set = addr_i[SET_BITS-1:0];
    assign tag = addr_i[ADDR_BITS-1:SET_BITS];

    always_comb begin
        hit_o   = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (rd_valid_i[w] && rd_tags_i[w] == tag) begin
                hit_o   = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end

        // walk downwards so the lowest invalid way wins
        have_free = 1'b0;
        free_way  = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!rd_valid_i[w]) begin
                have_free = 1'b1;
                free_way  = WAY_BITS'(w);
            end
        end
    end

    assign victim_way = have_free ? free_way : rd_evict_way_i;
    assign way_o = hit_o ? hit_way : victim_way;

    assign victim_dirty_o = rd_valid_i[victim_way] && rd_dirty_i[victim_way];
    assign victim_addr_o  = {rd_tags_i[victim_way], set};
    assign victim_line_o  = rd_lines_i[victim_way];

endmodule

/* tb.f */
llc_pkg.sv
llc_input_reg.sv
llc_way_lookup.sv
llc_store.sv
llc_ctrl.sv
llc_top.sv
tb_llc_checker.sv
tb_llc.sv

/* tb_llc.sv */
module tb_llc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_WAYS  = 4;
    localparam int NUM_SETS  = 16;
    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT   = 200;
    localparam int NUM_LINES = 1 << $bits(llc_pkg::line_addr_t);

    typedef struct packed {
        logic [3:0]     op;
        logic [3:0]     id;
        logic [11:0]    addr;
        logic [3:0]     offset;
        logic [31:0]    wdata;
        logic [3:0]     stall;
        logic [3:0]     nrd;
        logic [3:0]     nwr;
        llc_pkg::line_t line;
    } test_t;

    logic clk;
    logic rst;

    logic                  req_valid;
    logic                  req_ready;
    llc_pkg::llc_req_t     req;
    logic                  rsp_valid;
    logic                  rsp_ready;
    llc_pkg::llc_rsp_t     rsp;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    llc_pkg::llc_mem_req_t mem_req;
    logic                  mem_rsp_valid;
    logic                  mem_rsp_ready;
    llc_pkg::line_t        mem_rsp;

    logic [$bits(test_t)-1:0] raw [MAX_TESTS];
    test_t                    tests [MAX_TESTS];
    int                       num_tests;
    llc_pkg::line_t           mem [NUM_LINES];
    int                       tb_errors;

    always #4 clk = ~clk;

    llc_top #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_SETS(NUM_SETS)
    ) u_llc_top (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .req_i           (req),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .rsp_o           (rsp),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_o       (mem_req),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_ready_o (mem_rsp_ready),
        .mem_rsp_i       (mem_rsp)
    );

    tb_llc_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .req_ready_i     (req_ready),
        .rsp_valid_i     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .rsp_i           (rsp),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_i       (mem_req)
    );

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("%s at %0t ns", what, $time);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic drive_requests();
        int n;
        for (int i = 0; i < num_tests; i++) begin
            req.op     = llc_pkg::llc_op_e'(tests[i].op[0]);
            req.req_id = tests[i].id;
            req.addr   = tests[i].addr;
            req.offset = tests[i].offset[1:0];
            req.wdata  = tests[i].wdata;
            req_valid  = 1'b1;
            n = 0;
            while (!req_ready) begin
                if (n == TIMEOUT) abort_run("timed out waiting for request acceptance");
                next_cycle();
                n++;
            end
            next_cycle();
            req_valid = 1'b0;
            repeat ($urandom_range(2, 0)) next_cycle();
        end
    endtask

    // rsp ready stays low for the stall count of each row
    task automatic take_responses();
        int n;
        for (int k = 0; k < num_tests; k++) begin
            n = 0;
            while (!rsp_valid) begin
                if (n == TIMEOUT) abort_run("timed out waiting for a valid response");
                next_cycle();
                n++;
            end
            repeat (tests[k].stall) next_cycle();
            rsp_ready = 1'b1;
            next_cycle();
            rsp_ready = 1'b0;
        end
    endtask

    task automatic serve_memory();
        llc_pkg::llc_mem_req_t cur;
        int                    n;
        forever begin
            next_cycle();
            if (mem_req_valid) begin
                repeat ($urandom_range(3, 0)) next_cycle();
                cur = mem_req;
                mem_req_ready = 1'b1;
                next_cycle();
                mem_req_ready = 1'b0;
                if (cur.write) begin
                    mem[cur.addr] = cur.line;
                end else begin
                    repeat ($urandom_range(3, 0)) next_cycle();
                    mem_rsp = mem[cur.addr];
                    mem_rsp_valid = 1'b1;
                    n = 0;
                    while (!mem_rsp_ready) begin
                        if (n == TIMEOUT) begin
                            abort_run("timed out waiting for memory response acceptance");
                        end
                        next_cycle();
                        n++;
                    end
                    next_cycle();
                    mem_rsp_valid = 1'b0;
                end
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        tb_errors     = 0;
        void'($urandom(18117));

        // word w of line a holds a*4+w
        for (int a = 0; a < NUM_LINES; a++) begin
            for (int w = 0; w < llc_pkg::WORDS_PER_LINE; w++) begin
                mem[a][w] = llc_pkg::word_t'(a * 4 + w);
            end
        end

        for (int i = 0; i < MAX_TESTS; i++) begin
            raw[i] = '1;
        end
        $readmemh("llc_tests.txt", raw);
        num_tests = 0;
        while (num_tests < MAX_TESTS && raw[num_tests] !== '1) begin
            tests[num_tests] = test_t'(raw[num_tests]);
            num_tests++;
        end
        if (num_tests == 0) abort_run("no requests found in llc_tests.txt");

        fork
            serve_memory();
        join_none

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        fork
            drive_requests();
            take_responses();
        join

        repeat (4) next_cycle();
        if (u_checker.rsp_count != num_tests) begin
            tb_errors++;
            $display("%0d responses seen for %0d requests", u_checker.rsp_count, num_tests);
        end
        if (rsp_valid) begin
            tb_errors++;
            $display("rsp valid still high after the last response");
        end

        $display("errors: %0d, responses: %0d, memory reads: %0d, memory writes: %0d",
                 u_checker.errors + tb_errors, u_checker.rsp_count,
                 u_checker.rd_count, u_checker.wr_count);
        if (u_checker.errors + tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb_llc_checker.sv */
module tb_llc_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_ready_i,
    input  logic                  rsp_valid_i,
    input  logic                  rsp_ready_i,
    input  llc_pkg::llc_rsp_t     rsp_i,
    input  logic                  mem_req_valid_i,
    input  logic                  mem_req_ready_i,
    input  llc_pkg::llc_mem_req_t mem_req_i
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 64;

    // one row of llc_tests.txt
    typedef struct packed {
        logic [3:0]     op;
        logic [3:0]     id;
        logic [11:0]    addr;
        logic [3:0]     offset;
        logic [31:0]    wdata;
        logic [3:0]     stall;
        logic [3:0]     nrd;
        logic [3:0]     nwr;
        llc_pkg::line_t line;
    } test_t;

    logic [$bits(test_t)-1:0] raw [MAX_TESTS];
    test_t                    tests [MAX_TESTS];
    int                       num_tests;

    int errors;
    int rsp_count;
    int rd_count;
    int wr_count;

    // memory traffic since the last response
    int rd_seen;
    int wr_seen;

    logic              reset_seen;
    logic              held;
    llc_pkg::llc_rsp_t held_rsp;

    task automatic compare(input string name, input logic [131:0] got,
                           input logic [131:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    initial begin
        errors     = 0;
        rsp_count  = 0;
        rd_count   = 0;
        wr_count   = 0;
        rd_seen    = 0;
        wr_seen    = 0;
        reset_seen = 1'b0;
        held       = 1'b0;
        held_rsp   = '0;
        for (int i = 0; i < MAX_TESTS; i++) begin
            raw[i] = '1;
        end
        $readmemh("llc_tests.txt", raw);
        num_tests = 0;
        while (num_tests < MAX_TESTS && raw[num_tests] !== '1) begin
            tests[num_tests] = test_t'(raw[num_tests]);
            num_tests++;
        end
    end

    // sampled mid-cycle, between the DUT edge and the next one
    always @(negedge clk) begin : watch
        test_t exp;
        if (rst) begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                compare("rsp_valid_o after reset", rsp_valid_i, 1'b0);
                compare("mem_req_valid_o after reset", mem_req_valid_i, 1'b0);
                compare("req_ready_o after reset", req_ready_i, 1'b1);
            end

            if (held) begin
                if (!rsp_valid_i) begin
                    errors++;
                    $display("response %0d was withdrawn before rsp ready came", rsp_count);
                end else begin
                    compare("rsp_o under back-pressure", rsp_i, held_rsp);
                end
            end
            held     = rsp_valid_i && !rsp_ready_i;
            held_rsp = rsp_i;

            if (mem_req_valid_i && mem_req_ready_i) begin
                if (mem_req_i.write) begin
                    wr_seen++;
                    wr_count++;
                end else begin
                    rd_seen++;
                    rd_count++;
                end
            end

            if (rsp_valid_i && rsp_ready_i) begin
                if (rsp_count >= num_tests) begin
                    errors++;
                    $display("extra response with id %0h after the last request", rsp_i.req_id);
                end else begin
                    exp = tests[rsp_count];
                    compare("rsp_o.req_id", rsp_i.req_id, exp.id);
                    compare("rsp_o.line", rsp_i.line, exp.line);
                    if (rd_seen != exp.nrd || wr_seen != exp.nwr) begin
                        errors++;
                        $display("request %0d made %0d memory reads and %0d writes, not %0d and %0d",
                                 rsp_count, rd_seen, wr_seen, exp.nrd, exp.nwr);
                    end
                end
                rsp_count++;
                rd_seen = 0;
                wr_seen = 0;
            end
        end
    end

endmodule
